// ==== source/cpu_alu.sv ====
`timescale 1ns/1ps

module cpu_alu (
    input  cpu_pkg::decoded_t              dec,
    input  logic [riscv_isa_pkg::xlen-1:0] rs1_data,
    input  logic [riscv_isa_pkg::xlen-1:0] rs2_data,
    output logic [riscv_isa_pkg::xlen-1:0] result,
    output logic                           branch_taken
);

    logic [riscv_isa_pkg::xlen-1:0] operand_b;
    logic [4:0]                     shamt;
    logic                           equal;
    logic                           less_signed;
    logic                           less_unsigned;

    assign operand_b = dec.alu_reg ? rs2_data : dec.imm;
    assign shamt     = operand_b[4:0];

    always_comb begin
        result = rs1_data + operand_b; // Address path for loads, stores and JALR.
        if (dec.alu_reg || dec.alu_imm) begin
            case (dec.funct3)
                riscv_isa_pkg::funct3_add_sub: begin
                    if (dec.alu_reg && dec.alt) begin
                        result = rs1_data - operand_b;
                    end
                end
                riscv_isa_pkg::funct3_sll:  result = rs1_data << shamt;
                riscv_isa_pkg::funct3_slt:  result = {31'b0, $signed(rs1_data) < $signed(operand_b)};
                riscv_isa_pkg::funct3_sltu: result = {31'b0, rs1_data < operand_b};
                riscv_isa_pkg::funct3_xor:  result = rs1_data ^ operand_b;
                riscv_isa_pkg::funct3_srl_sra: begin
                    if (dec.alt) begin
                        result = $signed(rs1_data) >>> shamt;
                    end else begin
                        result = rs1_data >> shamt;
                    end
                end
                riscv_isa_pkg::funct3_or:   result = rs1_data | operand_b;
                riscv_isa_pkg::funct3_and:  result = rs1_data & operand_b;
            endcase
        end
    end

    assign equal         = rs1_data == rs2_data;
    assign less_signed   = $signed(rs1_data) < $signed(rs2_data);
    assign less_unsigned = rs1_data < rs2_data;

    always_comb begin
        case (dec.funct3)
            riscv_isa_pkg::funct3_beq:  branch_taken = equal;
            riscv_isa_pkg::funct3_bne:  branch_taken = !equal;
            riscv_isa_pkg::funct3_blt:  branch_taken = less_signed;
            riscv_isa_pkg::funct3_bge:  branch_taken = !less_signed;
            riscv_isa_pkg::funct3_bltu: branch_taken = less_unsigned;
            riscv_isa_pkg::funct3_bgeu: branch_taken = !less_unsigned;
            default:                    branch_taken = 1'b0;
        endcase
    end

endmodule

// ==== source/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control (
    input  logic                           clk,
    input  logic                           reset,
    output logic [riscv_isa_pkg::xlen-1:0] imem_addr,
    input  riscv_isa_pkg::instr_u          imem_data,
    output riscv_isa_pkg::instr_u          instr,
    output logic                           instr_valid,
    input  cpu_pkg::decoded_t              dec,
    input  logic [riscv_isa_pkg::xlen-1:0] alu_result,
    input  logic                           branch_taken,
    input  logic [riscv_isa_pkg::xlen-1:0] rs2_data,
    output logic                           rd_write,
    output riscv_isa_pkg::reg_addr_t       rd_addr,
    output logic [riscv_isa_pkg::xlen-1:0] rd_value,
    output cpu_pkg::apb_req_t              apb_req,
    input  cpu_pkg::apb_rsp_t              apb_rsp
);

    cpu_pkg::ctrl_state_t           state;
    logic [riscv_isa_pkg::xlen-1:0] pc;
    logic [riscv_isa_pkg::xlen-1:0] mem_addr;
    logic [riscv_isa_pkg::xlen-1:0] pc_plus_4;
    logic [riscv_isa_pkg::xlen-1:0] pc_plus_imm;
    logic [riscv_isa_pkg::xlen-1:0] next_pc;
    logic                           mem_op;

    assign pc_plus_4   = pc + 32'd4;
    assign pc_plus_imm = pc + dec.imm;
    assign mem_op      = dec.load || dec.store;

    always_comb begin
        if (dec.jalr) begin
            next_pc = {alu_result[31:1], 1'b0};
        end else if (dec.jal || (dec.branch && branch_taken)) begin
            next_pc = pc_plus_imm;
        end else begin
            next_pc = pc_plus_4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cpu_pkg::fetch;
            pc    <= cpu_pkg::reset_vector;
        end else begin
            case (state)
                cpu_pkg::fetch: state <= cpu_pkg::execute;
                cpu_pkg::execute: begin
                    if (mem_op) begin
                        state <= cpu_pkg::mem_setup;
                    end else begin
                        state <= cpu_pkg::fetch;
                        pc    <= next_pc;
                    end
                end
                cpu_pkg::mem_setup: state <= cpu_pkg::mem_access;
                default: begin
                    if (apb_rsp.pready) begin
                        state <= cpu_pkg::fetch;
                        pc    <= pc_plus_4;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpu_pkg::fetch) begin
            instr <= imem_data;
        end
        if (state == cpu_pkg::execute) begin
            mem_addr <= alu_result;
        end
    end

    assign imem_addr   = pc;
    assign instr_valid = state == cpu_pkg::execute;

    always_comb begin
        if (dec.load) begin
            rd_value = apb_rsp.prdata;
        end else if (dec.lui) begin
            rd_value = dec.imm;
        end else if (dec.auipc) begin
            rd_value = pc_plus_imm;
        end else if (dec.jal || dec.jalr) begin
            rd_value = pc_plus_4;
        end else begin
            rd_value = alu_result;
        end
    end

    assign rd_addr  = dec.rd;
    assign rd_write = !reset && dec.writes_rd
                      && ((state == cpu_pkg::execute && !dec.load)
                          || (state == cpu_pkg::mem_access && apb_rsp.pready));

    assign apb_req.paddr   = mem_addr;
    assign apb_req.psel    = state == cpu_pkg::mem_setup || state == cpu_pkg::mem_access;
    assign apb_req.penable = state == cpu_pkg::mem_access;
    assign apb_req.pwrite  = dec.store;
    assign apb_req.pwdata  = rs2_data; // Register file is idle until the transfer ends.

    a_apb_stable: assert property (@(posedge clk) disable iff (reset)
        apb_req.penable && !apb_rsp.pready |=> $stable(apb_req));

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        state == cpu_pkg::execute && !mem_op |-> next_pc[1:0] == 2'b00);

    a_addr_aligned: assert property (@(posedge clk) disable iff (reset)
        state == cpu_pkg::execute && mem_op |-> alu_result[1:0] == 2'b00);

endmodule

// ==== source/cpu_decoder.sv ====
`timescale 1ns/1ps

module cpu_decoder (
    input  logic                  clk,
    input  riscv_isa_pkg::instr_u instr,
    input  logic                  instr_valid,
    output cpu_pkg::decoded_t     dec
);

    always_comb begin
        dec        = '0;
        dec.rd     = instr.r.rd;
        dec.rs1    = instr.r.rs1;
        dec.rs2    = instr.r.rs2;
        dec.funct3 = instr.r.funct3;
        dec.alt    = instr.r.funct7[5];
        case (instr.r.opcode)
            riscv_isa_pkg::op: begin
                dec.alu_reg = 1'b1;
            end
            riscv_isa_pkg::op_imm: begin
                dec.alu_imm = 1'b1;
                dec.imm     = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            end
            riscv_isa_pkg::lui: begin
                dec.lui = 1'b1;
                dec.imm = {instr.u.imm_31_12, 12'b0};
            end
            riscv_isa_pkg::auipc: begin
                dec.auipc = 1'b1;
                dec.imm   = {instr.u.imm_31_12, 12'b0};
            end
            riscv_isa_pkg::branch: begin
                dec.branch = 1'b1;
                dec.imm    = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                              instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            end
            riscv_isa_pkg::jal: begin
                dec.jal = 1'b1;
                dec.imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                           instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            end
            riscv_isa_pkg::jalr: begin
                dec.jalr = 1'b1;
                dec.imm  = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            end
            riscv_isa_pkg::load: begin
                dec.load = 1'b1;
                dec.imm  = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            end
            riscv_isa_pkg::store: begin
                dec.store = 1'b1;
                dec.imm   = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
            end
            default: begin
                // FENCE and unknown opcodes do nothing.
            end
        endcase
        dec.writes_rd = (dec.alu_reg | dec.alu_imm | dec.lui | dec.auipc | dec.jal | dec.jalr
                         | dec.load) && (instr.r.rd != '0);
    end

    a_supported_opcode: assert property (@(posedge clk)
        instr_valid |-> instr.r.opcode inside {
            riscv_isa_pkg::op, riscv_isa_pkg::op_imm, riscv_isa_pkg::lui,
            riscv_isa_pkg::auipc, riscv_isa_pkg::branch, riscv_isa_pkg::jal,
            riscv_isa_pkg::jalr, riscv_isa_pkg::load, riscv_isa_pkg::store,
            riscv_isa_pkg::misc_mem});

endmodule

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

    localparam logic [riscv_isa_pkg::xlen-1:0] reset_vector = 32'h0001_0000;

    typedef enum logic [1:0] {
        fetch,
        execute,
        mem_setup,
        mem_access
    } ctrl_state_t;

    typedef struct packed {
        riscv_isa_pkg::reg_addr_t       rd;
        riscv_isa_pkg::reg_addr_t       rs1;
        riscv_isa_pkg::reg_addr_t       rs2;
        logic [riscv_isa_pkg::xlen-1:0] imm;
        logic [2:0]                     funct3;
        logic                           alt;       // funct7 bit 5.
        logic                           alu_reg;
        logic                           alu_imm;
        logic                           lui;
        logic                           auipc;
        logic                           branch;
        logic                           jal;
        logic                           jalr;
        logic                           load;
        logic                           store;
        logic                           writes_rd; // Never set for x0.
    } decoded_t;

    typedef struct packed {
        logic [riscv_isa_pkg::xlen-1:0] paddr;
        logic                           psel;
        logic                           penable;
        logic                           pwrite;
        logic [riscv_isa_pkg::xlen-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [riscv_isa_pkg::xlen-1:0] prdata;
        logic                           pready;
    } apb_rsp_t;

endpackage

// ==== source/cpu_register_file.sv ====
`timescale 1ns/1ps

module cpu_register_file (
    input  logic                           clk,
    input  riscv_isa_pkg::reg_addr_t       rs1_addr,
    input  riscv_isa_pkg::reg_addr_t       rs2_addr,
    output logic [riscv_isa_pkg::xlen-1:0] rs1_data,
    output logic [riscv_isa_pkg::xlen-1:0] rs2_data,
    input  logic                           write,
    input  riscv_isa_pkg::reg_addr_t       rd_addr,
    input  logic [riscv_isa_pkg::xlen-1:0] rd_value
);

    logic [riscv_isa_pkg::xlen-1:0] regs [31:1]; // No storage for x0.

    always_ff @(posedge clk) begin
        if (write) begin
            regs[rd_addr] <= rd_value;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic                           clk,
    input  logic                           reset,
    output logic [riscv_isa_pkg::xlen-1:0] imem_addr,
    input  riscv_isa_pkg::instr_u          imem_data,
    output cpu_pkg::apb_req_t              apb_req,
    input  cpu_pkg::apb_rsp_t              apb_rsp
);

    riscv_isa_pkg::instr_u          instr;
    logic                           instr_valid;
    cpu_pkg::decoded_t              dec;
    logic [riscv_isa_pkg::xlen-1:0] rs1_data;
    logic [riscv_isa_pkg::xlen-1:0] rs2_data;
    logic [riscv_isa_pkg::xlen-1:0] alu_result;
    logic                           branch_taken;
    logic                           rd_write;
    riscv_isa_pkg::reg_addr_t       rd_addr;
    logic [riscv_isa_pkg::xlen-1:0] rd_value;

    cpu_control control (
        .clk(clk),
        .reset(reset),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .instr(instr),
        .instr_valid(instr_valid),
        .dec(dec),
        .alu_result(alu_result),
        .branch_taken(branch_taken),
        .rs2_data(rs2_data),
        .rd_write(rd_write),
        .rd_addr(rd_addr),
        .rd_value(rd_value),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp)
    );

    cpu_decoder decoder (
        .clk(clk),
        .instr(instr),
        .instr_valid(instr_valid),
        .dec(dec)
    );

    cpu_register_file register_file (
        .clk(clk),
        .rs1_addr(dec.rs1),
        .rs2_addr(dec.rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .write(rd_write),
        .rd_addr(rd_addr),
        .rd_value(rd_value)
    );

    cpu_alu alu (
        .dec(dec),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .result(alu_result),
        .branch_taken(branch_taken)
    );

endmodule

// ==== source/riscv_isa_pkg.sv ====
package riscv_isa_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_addr_t;

    typedef enum logic [6:0] {
        op       = 7'b0110011,
        op_imm   = 7'b0010011,
        lui      = 7'b0110111,
        auipc    = 7'b0010111,
        branch   = 7'b1100011,
        jal      = 7'b1101111,
        jalr     = 7'b1100111,
        load     = 7'b0000011,
        store    = 7'b0100011,
        misc_mem = 7'b0001111
    } opcode_t;

    // ALU operations for OP and OP-IMM.
    localparam logic [2:0] funct3_add_sub = 3'b000;
    localparam logic [2:0] funct3_sll     = 3'b001;
    localparam logic [2:0] funct3_slt     = 3'b010;
    localparam logic [2:0] funct3_sltu    = 3'b011;
    localparam logic [2:0] funct3_xor     = 3'b100;
    localparam logic [2:0] funct3_srl_sra = 3'b101;
    localparam logic [2:0] funct3_or      = 3'b110;
    localparam logic [2:0] funct3_and     = 3'b111;

    // Branch conditions.
    localparam logic [2:0] funct3_beq  = 3'b000;
    localparam logic [2:0] funct3_bne  = 3'b001;
    localparam logic [2:0] funct3_blt  = 3'b100;
    localparam logic [2:0] funct3_bge  = 3'b101;
    localparam logic [2:0] funct3_bltu = 3'b110;
    localparam logic [2:0] funct3_bgeu = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_t    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_t     opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_t    opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        opcode_t     opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        opcode_t    opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_u;

endpackage

// ==== tb/cpu_clock_gen.sv ====
`timescale 1ns/1ps

module cpu_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period.
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== tb/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

    localparam logic [31:0] data_base   = 32'h0000_2000;
    localparam logic [11:0] marker_off  = 12'h200;
    localparam logic [31:0] marker_addr = data_base + 32'h200;
    localparam logic [31:0] done_addr   = data_base + 32'h3fc;
    localparam logic [31:0] val_a       = 32'h8765_4321; // x2.
    localparam logic [31:0] val_b       = 32'hffff_fff9; // x3, -7.
    localparam logic [31:0] val_c       = 32'd5;         // x4.

    logic                  clk;
    logic                  reset;
    logic [31:0]           imem_addr;
    riscv_isa_pkg::instr_u imem_data;
    cpu_pkg::apb_req_t     apb_req;
    cpu_pkg::apb_rsp_t     apb_rsp;

    riscv_isa_pkg::instr_u rom [0:127];
    logic [31:0]           rom_idx;
    logic [31:0]           mem [0:255];
    logic [31:0]           expected [0:255];
    logic                  expect_valid [0:255];
    int                    pc_idx;
    logic [11:0]           next_off;
    int                    expected_count;
    int                    writes_seen;
    integer                seed = 32'haa29_05f5;
    integer                rnd;
    logic [1:0]            wait_left;
    logic                  xfer_done;
    logic [7:0]            widx;

    cpu_clock_gen clock_gen (
        .clk(clk),
        .reset(reset)
    );

    cpu_top UUT (
        .clk(clk),
        .reset(reset),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp)
    );

    // Entry 127 always holds the spin loop.
    assign rom_idx   = (imem_addr - cpu_pkg::reset_vector) >> 2;
    assign imem_data = (rom_idx[31:7] == '0) ? rom[rom_idx[6:0]] : rom[127];
    assign xfer_done = apb_req.psel && apb_req.penable && apb_rsp.pready;
    assign widx      = apb_req.paddr[9:2];

    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic riscv_isa_pkg::instr_u r_format(input logic [6:0] f7,
            input riscv_isa_pkg::reg_addr_t rs2, input riscv_isa_pkg::reg_addr_t rs1,
            input logic [2:0] f3, input riscv_isa_pkg::reg_addr_t rd);
        riscv_isa_pkg::instr_u w;
        w.r = '{f7, rs2, rs1, f3, rd, riscv_isa_pkg::op};
        return w;
    endfunction

    function automatic riscv_isa_pkg::instr_u i_format(input logic [11:0] imm,
            input riscv_isa_pkg::reg_addr_t rs1, input logic [2:0] f3,
            input riscv_isa_pkg::reg_addr_t rd, input riscv_isa_pkg::opcode_t opc);
        riscv_isa_pkg::instr_u w;
        w.i = '{imm, rs1, f3, rd, opc};
        return w;
    endfunction

    function automatic riscv_isa_pkg::instr_u s_format(input riscv_isa_pkg::reg_addr_t rs2,
            input riscv_isa_pkg::reg_addr_t rs1, input logic [11:0] imm);
        riscv_isa_pkg::instr_u w;
        w.s = '{imm[11:5], rs2, rs1, 3'b010, imm[4:0], riscv_isa_pkg::store};
        return w;
    endfunction

    function automatic riscv_isa_pkg::instr_u b_format(input logic [2:0] f3,
            input riscv_isa_pkg::reg_addr_t rs1, input riscv_isa_pkg::reg_addr_t rs2,
            input logic [12:0] imm);
        riscv_isa_pkg::instr_u w;
        w.b = '{imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], riscv_isa_pkg::branch};
        return w;
    endfunction

    function automatic riscv_isa_pkg::instr_u u_format(input logic [19:0] imm,
            input riscv_isa_pkg::reg_addr_t rd, input riscv_isa_pkg::opcode_t opc);
        riscv_isa_pkg::instr_u w;
        w.u = '{imm, rd, opc};
        return w;
    endfunction

    function automatic riscv_isa_pkg::instr_u j_format(input riscv_isa_pkg::reg_addr_t rd,
            input logic [20:0] imm);
        riscv_isa_pkg::instr_u w;
        w.j = '{imm[20], imm[10:1], imm[11], imm[19:12], rd, riscv_isa_pkg::jal};
        return w;
    endfunction

    function automatic logic [31:0] pc_now();
        return cpu_pkg::reset_vector + pc_idx * 4;
    endfunction

    task automatic emit(input riscv_isa_pkg::instr_u w);
        rom[pc_idx] = w;
        pc_idx++;
    endtask

    task automatic expect_store(input riscv_isa_pkg::reg_addr_t rs2, input logic [31:0] value);
        emit(s_format(rs2, 5'd1, next_off));
        expected[next_off[9:2]]     = value;
        expect_valid[next_off[9:2]] = 1'b1;
        expected_count++;
        next_off += 12'd4;
    endtask

    task automatic result_store(input riscv_isa_pkg::instr_u w, input logic [31:0] value);
        emit(w);
        expect_store(5'd5, value);
    endtask

    // Either path past a wrong outcome runs into the marker store.
    task automatic branch_check(input logic [2:0] f3, input riscv_isa_pkg::reg_addr_t rs1,
            input riscv_isa_pkg::reg_addr_t rs2, input logic taken);
        emit(b_format(f3, rs1, rs2, 13'd8));
        if (!taken) begin
            emit(j_format(5'd0, 21'd8));
        end
        emit(s_format(5'd0, 5'd1, marker_off));
    endtask

    task automatic build_program();
        logic [31:0] link;
        logic [11:0] off_a;
        for (int i = 0; i < 128; i++) begin
            rom[i] = j_format(5'd0, 21'd0); // Spin in place.
        end
        for (int i = 0; i < 256; i++) begin
            mem[i]          = ~(data_base + i * 4);
            expect_valid[i] = 1'b0;
        end
        pc_idx         = 0;
        next_off       = 12'h000;
        expected_count = 0;
        emit(u_format(20'h00002, 5'd1, riscv_isa_pkg::lui));
        emit(u_format(20'h87654, 5'd2, riscv_isa_pkg::lui));
        emit(i_format(12'h321, 5'd2, riscv_isa_pkg::funct3_add_sub, 5'd2, riscv_isa_pkg::op_imm));
        emit(i_format(12'hff9, 5'd0, riscv_isa_pkg::funct3_add_sub, 5'd3, riscv_isa_pkg::op_imm));
        emit(i_format(12'h005, 5'd0, riscv_isa_pkg::funct3_add_sub, 5'd4, riscv_isa_pkg::op_imm));
        result_store(r_format(7'h00, 5'd4, 5'd2, riscv_isa_pkg::funct3_add_sub, 5'd5), val_a + val_c);
        result_store(r_format(7'h20, 5'd3, 5'd2, riscv_isa_pkg::funct3_add_sub, 5'd5), val_a - val_b);
        result_store(r_format(7'h00, 5'd4, 5'd2, riscv_isa_pkg::funct3_sll, 5'd5), val_a << 5);
        result_store(r_format(7'h00, 5'd4, 5'd3, riscv_isa_pkg::funct3_slt, 5'd5), 32'd1);
        result_store(r_format(7'h00, 5'd4, 5'd3, riscv_isa_pkg::funct3_sltu, 5'd5), 32'd0);
        result_store(r_format(7'h00, 5'd3, 5'd2, riscv_isa_pkg::funct3_xor, 5'd5), val_a ^ val_b);
        result_store(r_format(7'h00, 5'd4, 5'd2, riscv_isa_pkg::funct3_srl_sra, 5'd5), val_a >> 5);
        result_store(r_format(7'h20, 5'd4, 5'd2, riscv_isa_pkg::funct3_srl_sra, 5'd5),
                     {{5{val_a[31]}}, val_a[31:5]});
        result_store(r_format(7'h00, 5'd3, 5'd2, riscv_isa_pkg::funct3_or, 5'd5), val_a | val_b);
        result_store(r_format(7'h00, 5'd3, 5'd2, riscv_isa_pkg::funct3_and, 5'd5), val_a & val_b);
        result_store(i_format(12'hf9c, 5'd2, riscv_isa_pkg::funct3_add_sub, 5'd5,
                              riscv_isa_pkg::op_imm), val_a - 32'd100);
        result_store(i_format(12'hffa, 5'd3, riscv_isa_pkg::funct3_slt, 5'd5,
                              riscv_isa_pkg::op_imm), 32'd1);
        result_store(i_format(12'hfff, 5'd4, riscv_isa_pkg::funct3_sltu, 5'd5,
                              riscv_isa_pkg::op_imm), 32'd1);
        result_store(i_format(12'h7ff, 5'd2, riscv_isa_pkg::funct3_xor, 5'd5,
                              riscv_isa_pkg::op_imm), val_a ^ 32'h7ff);
        result_store(i_format(12'h0f0, 5'd3, riscv_isa_pkg::funct3_or, 5'd5,
                              riscv_isa_pkg::op_imm), val_b | 32'hf0);
        result_store(i_format(12'h0ff, 5'd2, riscv_isa_pkg::funct3_and, 5'd5,
                              riscv_isa_pkg::op_imm), val_a & 32'hff);
        result_store(i_format(12'h004, 5'd2, riscv_isa_pkg::funct3_sll, 5'd5,
                              riscv_isa_pkg::op_imm), val_a << 4);
        result_store(i_format(12'h008, 5'd2, riscv_isa_pkg::funct3_srl_sra, 5'd5,
                              riscv_isa_pkg::op_imm), val_a >> 8);
        result_store(i_format(12'h408, 5'd2, riscv_isa_pkg::funct3_srl_sra, 5'd5,
                              riscv_isa_pkg::op_imm), {{8{val_a[31]}}, val_a[31:8]});
        result_store(u_format(20'habcde, 5'd5, riscv_isa_pkg::lui), 32'habcd_e000);
        result_store(u_format(20'h00001, 5'd5, riscv_isa_pkg::auipc), pc_now() + 32'h1000);
        branch_check(riscv_isa_pkg::funct3_beq, 5'd4, 5'd4, 1'b1);
        branch_check(riscv_isa_pkg::funct3_beq, 5'd2, 5'd4, 1'b0);
        branch_check(riscv_isa_pkg::funct3_bne, 5'd2, 5'd4, 1'b1);
        branch_check(riscv_isa_pkg::funct3_bne, 5'd4, 5'd4, 1'b0);
        branch_check(riscv_isa_pkg::funct3_blt, 5'd3, 5'd4, 1'b1);
        branch_check(riscv_isa_pkg::funct3_blt, 5'd4, 5'd3, 1'b0);
        branch_check(riscv_isa_pkg::funct3_bge, 5'd4, 5'd3, 1'b1);
        branch_check(riscv_isa_pkg::funct3_bge, 5'd3, 5'd4, 1'b0);
        branch_check(riscv_isa_pkg::funct3_bltu, 5'd4, 5'd3, 1'b1);
        branch_check(riscv_isa_pkg::funct3_bltu, 5'd3, 5'd4, 1'b0);
        branch_check(riscv_isa_pkg::funct3_bgeu, 5'd3, 5'd4, 1'b1);
        branch_check(riscv_isa_pkg::funct3_bgeu, 5'd4, 5'd3, 1'b0);
        link = pc_now() + 32'd4;
        emit(j_format(5'd6, 21'd8));
        emit(s_format(5'd0, 5'd1, marker_off));
        expect_store(5'd6, link);
        link = pc_now() + 32'd8; // JALR target is auipc + 16 once bit 0 is cleared.
        emit(u_format(20'h00000, 5'd7, riscv_isa_pkg::auipc));
        emit(i_format(12'd17, 5'd7, 3'b000, 5'd8, riscv_isa_pkg::jalr));
        emit(s_format(5'd0, 5'd1, marker_off));
        emit(s_format(5'd0, 5'd1, marker_off));
        expect_store(5'd8, link);
        off_a = next_off;
        expect_store(5'd2, val_a);
        emit(i_format(off_a, 5'd1, 3'b010, 5'd9, riscv_isa_pkg::load));
        emit(i_format(12'h001, 5'd9, riscv_isa_pkg::funct3_add_sub, 5'd9, riscv_isa_pkg::op_imm));
        expect_store(5'd9, val_a + 32'd1);
        emit(i_format(12'h07b, 5'd0, riscv_isa_pkg::funct3_add_sub, 5'd0, riscv_isa_pkg::op_imm));
        emit(u_format(20'h12345, 5'd0, riscv_isa_pkg::lui));
        expect_store(5'd0, 32'd0);
        next_off = done_addr[11:0];
        expect_store(5'd0, 32'd0);
    endtask

    // APB slave memory with 0 to 3 extra wait cycles.
    always @(posedge clk) begin
        if (reset) begin
            apb_rsp.pready <= 1'b0;
        end else if (apb_req.psel && !apb_req.penable) begin
            rnd = $random(seed);
            wait_left      <= rnd[1:0];
            apb_rsp.pready <= rnd[1:0] == 2'd0;
            apb_rsp.prdata <= mem[widx];
        end else if (xfer_done) begin
            if (apb_req.pwrite) begin
                mem[widx] <= apb_req.pwdata;
            end
            apb_rsp.pready <= 1'b0;
        end else if (apb_req.penable) begin
            wait_left      <= wait_left - 2'd1;
            apb_rsp.pready <= wait_left == 2'd1;
        end
    end

    a_reset_idle: assert property (@(posedge clk)
        reset |=> !apb_req.psel && !apb_req.penable)
        else fail_with("APB request active during reset");

    a_reset_pc: assert property (@(posedge clk)
        reset |=> imem_addr == cpu_pkg::reset_vector)
        else fail_with($sformatf("FAILED imem_addr after reset: got %h, expected %h",
                                 $sampled(imem_addr), cpu_pkg::reset_vector));

    a_setup_first: assert property (@(posedge clk) disable iff (reset)
        $rose(apb_req.penable) |-> $past(apb_req.psel && !apb_req.penable))
        else fail_with("APB access phase started without a setup cycle");

    a_enable_with_sel: assert property (@(posedge clk) disable iff (reset)
        apb_req.penable |-> apb_req.psel)
        else fail_with("APB penable high while psel is low");

    a_setup_to_access: assert property (@(posedge clk) disable iff (reset)
        apb_req.psel && !apb_req.penable |=> apb_req.psel && apb_req.penable)
        else fail_with("APB setup cycle not followed by an access cycle");

    a_wait_stable: assert property (@(posedge clk) disable iff (reset)
        apb_req.psel && apb_req.penable && !apb_rsp.pready |=> $stable(apb_req))
        else fail_with("APB request changed during a wait state");

    a_no_marker: assert property (@(posedge clk) disable iff (reset)
        xfer_done && apb_req.pwrite |-> apb_req.paddr != marker_addr)
        else fail_with("Store reached a marker address after a wrong branch or jump");

    a_store_address: assert property (@(posedge clk) disable iff (reset)
        xfer_done && apb_req.pwrite |-> apb_req.paddr[31:10] == data_base[31:10]
                                        && expect_valid[widx])
        else fail_with($sformatf("Store to an unexpected address %h", $sampled(apb_req.paddr)));

    a_store_data: assert property (@(posedge clk) disable iff (reset)
        xfer_done && apb_req.pwrite && expect_valid[widx] |-> apb_req.pwdata == expected[widx])
        else fail_with($sformatf("FAILED pwdata at paddr %h: got %h, expected %h",
                                 $sampled(apb_req.paddr), $sampled(apb_req.pwdata),
                                 expected[$sampled(widx)]));

    initial begin
        int   cycles;
        int   transfers;
        logic done;
        apb_rsp     = '0;
        wait_left   = 2'd0;
        writes_seen = 0;
        build_program();
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) begin
                fail_with("Reset was never released");
            end
        end while (reset);
        done      = 1'b0;
        transfers = 0;
        while (!done) begin
            cycles = 0;
            do begin
                @(posedge clk);
                cycles++;
                if (cycles > 100) begin
                    fail_with("No APB transfer completed within 100 cycles");
                end
            end while (!xfer_done);
            transfers++;
            if (apb_req.pwrite) begin
                writes_seen++;
                done = apb_req.paddr == done_addr;
            end
            if (transfers > 64) begin
                fail_with("Done store not reached after 64 transfers");
            end
        end
        @(posedge clk); // Let the last transfer's checks run.
        if (writes_seen != expected_count) begin
            fail_with($sformatf("FAILED store count: got %h, expected %h",
                                writes_seen, expected_count));
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
source/riscv_isa_pkg.sv
source/cpu_pkg.sv
source/cpu_decoder.sv
source/cpu_register_file.sv
source/cpu_alu.sv
source/cpu_control.sv
source/cpu_top.sv
tb/cpu_clock_gen.sv
tb/cpu_tb.sv
